// ==== design/vread_bus_pkg.sv ====
package vread_bus_pkg;

   // external Wishbone master side
   parameter int BUS_ADDR_W = 32;

   // one buffer word holds exactly one bus word
   parameter int BUS_DATA_W = 32;

   // byte address step between consecutive bus words
   parameter int BUS_BYTES = BUS_DATA_W / 8;

endpackage

// ==== design/vread_cfg_pkg.sv ====
package vread_cfg_pkg;

   // symbol address into the local buffer, top bit picks the half
   parameter int BUF_ADDR_W = 10;

   // period and duty fields of a pattern
   parameter int PERIOD_W = 8;

   // iteration counts, both loop levels
   parameter int ITER_W = 8;

   // start delay of the output stream
   parameter int DELAY_W = 7;

   // read length in bus words
   parameter int LEN_W = 8;

endpackage

// ==== design/vread_ctrl.sv ====
module vread_ctrl (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run_i,
   input  logic                                read_en_i,
   input  logic                                ping_pong_i,
   input  logic [vread_bus_pkg::BUS_ADDR_W-1:0] ext_addr_i,
   input  logic [vread_cfg_pkg::LEN_W-1:0]      read_len_i,
   input  logic                                data_ready_i,
   input  logic                                out_done_i,
   input  logic                                wb_ack_i,
   output logic                                wb_cyc_o,
   output logic                                wb_stb_o,
   output logic [vread_bus_pkg::BUS_ADDR_W-1:0] wb_adr_o,
   output logic                                rd_run_o,
   output logic                                out_run_o,
   output logic                                wr_half_o,
   output logic                                rd_half_o,
   output logic                                done_o
);
   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;

   logic             rd_done;
   logic             out_done;
   logic             pp_state;
   logic [LEN_W-1:0] ack_cnt;
   logic             start_rd;
   logic             ack_ok;
   logic             last_ack;

   // a zero length read counts as done right away
   assign start_rd = run_i && read_en_i && (read_len_i != '0);
   assign ack_ok   = wb_stb_o && wb_ack_i;
   assign last_ack = ack_ok && (ack_cnt == read_len_i - 1'b1);

   assign rd_run_o  = run_i && read_en_i;
   assign out_run_o = run_i;
   assign done_o    = rd_done && out_done;

   // fill one half while the other drains
   assign wr_half_o = ping_pong_i && !pp_state;
   assign rd_half_o = ping_pong_i && pp_state;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
         out_done <= 1'b1;
      end else if (run_i) begin
         pp_state <= ping_pong_i ? !pp_state : 1'b0;
         out_done <= 1'b0;
      end else if (out_done_i) begin
         out_done <= 1'b1;
      end
   end

   // classic read cycle, cyc held over the whole block
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wb_cyc_o <= 1'b0;
         wb_stb_o <= 1'b0;
         rd_done  <= 1'b1;
         ack_cnt  <= '0;
      end else if (run_i) begin
         wb_cyc_o <= start_rd;
         wb_stb_o <= start_rd;
         rd_done  <= !start_rd;
         ack_cnt  <= '0;
      end else if (ack_ok) begin
         wb_stb_o <= 1'b0;
         ack_cnt  <= ack_cnt + 1'b1;
         if (last_ack) begin
            wb_cyc_o <= 1'b0;
            rd_done  <= 1'b1;
         end
      end else if (!rd_done && !wb_stb_o && data_ready_i) begin
         wb_stb_o <= 1'b1;
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wb_adr_o <= '0;
      end else if (run_i && read_en_i) begin
         wb_adr_o <= ext_addr_i;
      end else if (ack_ok) begin
         wb_adr_o <= wb_adr_o + BUS_ADDR_W'(BUS_BYTES);
      end
   end

   assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o);

   // slave may only answer a live strobe
   assert property (@(posedge clk) disable iff (rst) !wb_stb_o |-> !wb_ack_i);

endmodule

// ==== design/pattern_addr_gen.sv ====
module pattern_addr_gen #(
   parameter int LEVELS = 2
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] start_i,
   input  logic [vread_cfg_pkg::PERIOD_W-1:0]   per_i,
   input  logic [vread_cfg_pkg::PERIOD_W-1:0]   duty_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] incr_i,
   input  logic [vread_cfg_pkg::ITER_W-1:0]     iter_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] shift_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] incr2_i,
   input  logic [vread_cfg_pkg::ITER_W-1:0]     iter2_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] shift2_i,
   input  logic [vread_cfg_pkg::DELAY_W-1:0]    delay_i,
   input  logic                                ready_i,
   output logic                                valid_o,
   output logic [vread_cfg_pkg::BUF_ADDR_W-1:0] addr_o,
   output logic                                done_o
);
   import vread_cfg_pkg::*;

   logic                  active;
   logic [DELAY_W-1:0]    delay_cnt;
   logic [PERIOD_W-1:0]   per_cnt;
   logic [ITER_W-1:0]     iter_cnt;
   logic [BUF_ADDR_W-1:0] addr_q;
   logic [BUF_ADDR_W-1:0] base_q;
   logic                  done_q;
   logic                  step;
   logic                  per_end;
   logic                  block_end;
   logic                  last_pass;
   logic                  finish;
   logic [BUF_ADDR_W-1:0] pass_base_nxt;

   // first duty cycles of each period emit
   assign valid_o = active && (delay_cnt == '0) && (per_cnt < duty_i);
   assign addr_o  = addr_q;
   assign done_o  = done_q;

   // counters freeze only while an emitted address waits for ready
   assign step      = active && (delay_cnt == '0) && !(valid_o && !ready_i);
   assign per_end   = (per_cnt == per_i - 1'b1);
   assign block_end = per_end && (iter_cnt == iter_i - 1'b1);
   assign finish    = block_end && last_pass;

   generate
      if (LEVELS > 1) begin : g_two_level
         logic [ITER_W-1:0]     iter2_cnt;
         logic [BUF_ADDR_W-1:0] base2_q;

         assign last_pass = (iter2_cnt == iter2_i - 1'b1);
         // outer pass step is shift2 plus incr2
         assign pass_base_nxt = base2_q + shift2_i + incr2_i;

         always_ff @(posedge clk, posedge rst) begin
            if (rst) begin
               iter2_cnt <= '0;
            end else if (run_i) begin
               iter2_cnt <= '0;
            end else if (step && block_end && !last_pass) begin
               iter2_cnt <= iter2_cnt + 1'b1;
            end
         end

         always_ff @(posedge clk) begin
            if (run_i) begin
               base2_q <= start_i;
            end else if (step && block_end) begin
               base2_q <= pass_base_nxt;
            end
         end
      end else begin : g_one_level
         assign last_pass     = 1'b1;
         assign pass_base_nxt = base_q + shift_i;
      end
   endgenerate

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         active    <= 1'b0;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         done_q    <= 1'b0;
      end else begin
         done_q <= step && finish;
         if (run_i) begin
            active    <= 1'b1;
            delay_cnt <= delay_i;
            per_cnt   <= '0;
            iter_cnt  <= '0;
         end else if (active && (delay_cnt != '0)) begin
            delay_cnt <= delay_cnt - 1'b1;
         end else if (step) begin
            if (per_end) begin
               per_cnt  <= '0;
               iter_cnt <= block_end ? '0 : iter_cnt + 1'b1;
               if (finish) begin
                  active <= 1'b0;
               end
            end else begin
               per_cnt <= per_cnt + 1'b1;
            end
         end
      end
   end

   // period base and running address
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q <= start_i;
         base_q <= start_i;
      end else if (step) begin
         if (block_end) begin
            addr_q <= pass_base_nxt;
            base_q <= pass_base_nxt;
         end else if (per_end) begin
            addr_q <= base_q + shift_i;
            base_q <= base_q + shift_i;
         end else if (valid_o) begin
            addr_q <= addr_q + incr_i;
         end
      end
   end

endmodule

// ==== design/buffer_writer.sv ====
module buffer_writer (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                gen_valid_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] gen_addr_i,
   input  logic                                wb_ack_i,
   input  logic [vread_bus_pkg::BUS_DATA_W-1:0] wb_dat_i,
   output logic                                gen_ready_o,
   output logic                                data_ready_o,
   output logic                                mem_we_o,
   output logic [vread_cfg_pkg::BUF_ADDR_W-1:0] mem_waddr_o,
   output logic [vread_bus_pkg::BUS_DATA_W-1:0] mem_wdata_o
);

   logic take;

   // generator keeps addr and valid up until ready, so its output is the held slot
   assign take = gen_valid_i && wb_ack_i;

   // next request only once the current word has landed
   assign data_ready_o = gen_valid_i && !wb_ack_i;

   // word goes into the buffer on the ack cycle itself
   assign mem_we_o    = take;
   assign mem_waddr_o = gen_addr_i;
   assign mem_wdata_o = wb_dat_i;

   // releasing the address steps the generator
   assign gen_ready_o = take;

   // every returned word needs a target slot
   assert property (@(posedge clk) disable iff (rst) wb_ack_i |-> gen_valid_i);

endmodule

// ==== design/dual_port_buffer.sv ====
module dual_port_buffer #(
   parameter int DEPTH_W = 10,
   parameter int WIDTH   = 32
) (
   input  logic               clk,
   input  logic               we_i,
   input  logic [DEPTH_W-1:0] waddr_i,
   input  logic [WIDTH-1:0]   wdata_i,
   input  logic               re_i,
   input  logic [DEPTH_W-1:0] raddr_i,
   output logic [WIDTH-1:0]   rdata_o,
   output logic               rvalid_o
);

   logic [WIDTH-1:0] mem [2**DEPTH_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // read data and valid line up one cycle after the request
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
      rvalid_o <= re_i;
   end

endmodule

// ==== design/symbol_select.sv ====
module symbol_select #(
   parameter int DATA_W = 8
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] sym_addr_i,
   input  logic [vread_bus_pkg::BUS_DATA_W-1:0] word_i,
   output logic [vread_cfg_pkg::BUF_ADDR_W-1:0] word_addr_o,
   output logic [DATA_W-1:0]                    data_o
);
   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;

   localparam int SYMS  = BUS_DATA_W / DATA_W;
   localparam int SEL_W = $clog2(SYMS);

   generate
      if (SEL_W > 0) begin : g_narrow
         logic [SEL_W-1:0]      sel_q;
         logic [BUF_ADDR_W-2:0] word_low;

         // half bit stays on top, the rest becomes a word index
         assign word_low    = sym_addr_i[BUF_ADDR_W-2:0] >> SEL_W;
         assign word_addr_o = {sym_addr_i[BUF_ADDR_W-1], word_low};

         // select follows the buffer read latency
         always_ff @(posedge clk, posedge rst) begin
            if (rst) begin
               sel_q <= '0;
            end else begin
               sel_q <= sym_addr_i[SEL_W-1:0];
            end
         end

         assign data_o = word_i[sel_q*DATA_W +: DATA_W];
      end else begin : g_full
         assign word_addr_o = sym_addr_i;
         assign data_o      = word_i;
      end
   endgenerate

endmodule

// ==== design/vread_top.sv ====
module vread_top #(
   parameter int DATA_W = vread_bus_pkg::BUS_DATA_W / vread_bus_pkg::BUS_BYTES,
   parameter int LEVELS = 2
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run_i,
   output logic                                done_o,
   output logic                                wb_cyc_o,
   output logic                                wb_stb_o,
   output logic [vread_bus_pkg::BUS_ADDR_W-1:0] wb_adr_o,
   input  logic [vread_bus_pkg::BUS_DATA_W-1:0] wb_dat_i,
   input  logic                                wb_ack_i,
   output logic [DATA_W-1:0]                    data_o,
   output logic                                data_valid_o,
   input  logic [vread_bus_pkg::BUS_ADDR_W-1:0] ext_addr_i,
   input  logic [vread_cfg_pkg::LEN_W-1:0]      read_len_i,
   input  logic                                read_en_i,
   input  logic                                ping_pong_i,
   input  logic [vread_cfg_pkg::PERIOD_W-1:0]   rd_per_i,
   input  logic [vread_cfg_pkg::PERIOD_W-1:0]   rd_duty_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] rd_incr_i,
   input  logic [vread_cfg_pkg::ITER_W-1:0]     rd_iter_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] rd_shift_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] out_start_i,
   input  logic [vread_cfg_pkg::PERIOD_W-1:0]   out_per_i,
   input  logic [vread_cfg_pkg::PERIOD_W-1:0]   out_duty_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] out_incr_i,
   input  logic [vread_cfg_pkg::ITER_W-1:0]     out_iter_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] out_shift_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] out_incr2_i,
   input  logic [vread_cfg_pkg::ITER_W-1:0]     out_iter2_i,
   input  logic [vread_cfg_pkg::BUF_ADDR_W-1:0] out_shift2_i,
   input  logic [vread_cfg_pkg::DELAY_W-1:0]    out_delay_i
);
   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;

   logic                  rd_run;
   logic                  out_run;
   logic                  wr_half;
   logic                  rd_half;
   logic                  out_done;
   logic                  data_ready;
   logic                  rd_valid;
   logic                  rd_ready;
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic                  out_valid;
   logic [BUF_ADDR_W-1:0] out_addr;
   logic                  mem_we;
   logic [BUF_ADDR_W-1:0] mem_waddr;
   logic [BUS_DATA_W-1:0] mem_wdata;
   logic [BUF_ADDR_W-1:0] rd_word_addr;
   logic [BUS_DATA_W-1:0] rd_word;
   logic [BUF_ADDR_W-1:0] rd_start;
   logic [BUF_ADDR_W-1:0] out_start;

   // half bits go on top of each start address
   assign rd_start  = {wr_half, {(BUF_ADDR_W-1){1'b0}}};
   assign out_start = {rd_half, out_start_i[BUF_ADDR_W-2:0]};

   vread_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .read_en_i    (read_en_i),
      .ping_pong_i  (ping_pong_i),
      .ext_addr_i   (ext_addr_i),
      .read_len_i   (read_len_i),
      .data_ready_i (data_ready),
      .out_done_i   (out_done),
      .wb_ack_i     (wb_ack_i),
      .wb_cyc_o     (wb_cyc_o),
      .wb_stb_o     (wb_stb_o),
      .wb_adr_o     (wb_adr_o),
      .rd_run_o     (rd_run),
      .out_run_o    (out_run),
      .wr_half_o    (wr_half),
      .rd_half_o    (rd_half),
      .done_o       (done_o)
   );

   // word addresses, single loop, no start delay
   pattern_addr_gen #(
      .LEVELS (1)
   ) u_rd_gen (
      .clk      (clk),
      .rst      (rst),
      .run_i    (rd_run),
      .start_i  (rd_start),
      .per_i    (rd_per_i),
      .duty_i   (rd_duty_i),
      .incr_i   (rd_incr_i),
      .iter_i   (rd_iter_i),
      .shift_i  (rd_shift_i),
      .incr2_i  ('0),
      .iter2_i  ('0),
      .shift2_i ('0),
      .delay_i  ('0),
      .ready_i  (rd_ready),
      .valid_o  (rd_valid),
      .addr_o   (rd_addr),
      .done_o   ()
   );

   pattern_addr_gen #(
      .LEVELS (LEVELS)
   ) u_out_gen (
      .clk      (clk),
      .rst      (rst),
      .run_i    (out_run),
      .start_i  (out_start),
      .per_i    (out_per_i),
      .duty_i   (out_duty_i),
      .incr_i   (out_incr_i),
      .iter_i   (out_iter_i),
      .shift_i  (out_shift_i),
      .incr2_i  (out_incr2_i),
      .iter2_i  (out_iter2_i),
      .shift2_i (out_shift2_i),
      .delay_i  (out_delay_i),
      .ready_i  (1'b1),
      .valid_o  (out_valid),
      .addr_o   (out_addr),
      .done_o   (out_done)
   );

   buffer_writer u_writer (
      .clk          (clk),
      .rst          (rst),
      .gen_valid_i  (rd_valid),
      .gen_addr_i   (rd_addr),
      .wb_ack_i     (wb_ack_i),
      .wb_dat_i     (wb_dat_i),
      .gen_ready_o  (rd_ready),
      .data_ready_o (data_ready),
      .mem_we_o     (mem_we),
      .mem_waddr_o  (mem_waddr),
      .mem_wdata_o  (mem_wdata)
   );

   dual_port_buffer #(
      .DEPTH_W (BUF_ADDR_W),
      .WIDTH   (BUS_DATA_W)
   ) u_buf (
      .clk      (clk),
      .we_i     (mem_we),
      .waddr_i  (mem_waddr),
      .wdata_i  (mem_wdata),
      .re_i     (out_valid),
      .raddr_i  (rd_word_addr),
      .rdata_o  (rd_word),
      .rvalid_o (data_valid_o)
   );

   symbol_select #(
      .DATA_W (DATA_W)
   ) u_sym (
      .clk         (clk),
      .rst         (rst),
      .sym_addr_i  (out_addr),
      .word_i      (rd_word),
      .word_addr_o (rd_word_addr),
      .data_o      (data_o)
   );

endmodule

// ==== dv/tb_vread.sv ====
module tb_vread;
   import vread_bus_pkg::*;
   import vread_cfg_pkg::*;

   localparam int SYM_W   = 8;
   localparam int SYMS    = BUS_DATA_W / SYM_W;
   localparam int HALF_SZ = 2 ** (BUF_ADDR_W - 1);
   localparam int TIMEOUT = 2000;
   localparam logic [BUS_DATA_W-1:0] MEM_KEY = 32'h5a3c_96e1;

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  done;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic [BUS_ADDR_W-1:0] wb_adr;
   logic [BUS_DATA_W-1:0] wb_dat;
   logic                  wb_ack;
   logic [SYM_W-1:0]      data;
   logic                  data_valid;
   logic [BUS_ADDR_W-1:0] ext_addr;
   logic [LEN_W-1:0]      read_len;
   logic                  read_en;
   logic                  ping_pong;
   logic [PERIOD_W-1:0]   rd_per;
   logic [PERIOD_W-1:0]   rd_duty;
   logic [BUF_ADDR_W-1:0] rd_incr;
   logic [ITER_W-1:0]     rd_iter;
   logic [BUF_ADDR_W-1:0] rd_shift;
   logic [BUF_ADDR_W-1:0] out_start;
   logic [PERIOD_W-1:0]   out_per;
   logic [PERIOD_W-1:0]   out_duty;
   logic [BUF_ADDR_W-1:0] out_incr;
   logic [ITER_W-1:0]     out_iter;
   logic [BUF_ADDR_W-1:0] out_shift;
   logic [BUF_ADDR_W-1:0] out_incr2;
   logic [ITER_W-1:0]     out_iter2;
   logic [BUF_ADDR_W-1:0] out_shift2;
   logic [DELAY_W-1:0]    out_delay;

   // reference buffer image, word index is half * HALF_SZ + word
   logic [BUS_DATA_W-1:0] model_buf [2*HALF_SZ];
   logic [SYM_W-1:0]      exp_q [$];
   logic [SYM_W-1:0]      got_q [$];
   logic                  model_pp = 1'b0;
   logic                  cyc_seen = 1'b0;
   logic [BUS_ADDR_W-1:0] next_adr = '0;
   integer                seed = 80329;
   int                    max_delay = 0;
   int                    ack_wait = 0;
   int                    xfer_cnt = 0;
   int                    err_cnt = 0;
   int                    chk_cnt = 0;
   int                    test_cnt = 0;
   string                 cur_test = "idle";

   vread_top #(
      .DATA_W (SYM_W),
      .LEVELS (2)
   ) u_vread_top (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run),
      .done_o       (done),
      .wb_cyc_o     (wb_cyc),
      .wb_stb_o     (wb_stb),
      .wb_adr_o     (wb_adr),
      .wb_dat_i     (wb_dat),
      .wb_ack_i     (wb_ack),
      .data_o       (data),
      .data_valid_o (data_valid),
      .ext_addr_i   (ext_addr),
      .read_len_i   (read_len),
      .read_en_i    (read_en),
      .ping_pong_i  (ping_pong),
      .rd_per_i     (rd_per),
      .rd_duty_i    (rd_duty),
      .rd_incr_i    (rd_incr),
      .rd_iter_i    (rd_iter),
      .rd_shift_i   (rd_shift),
      .out_start_i  (out_start),
      .out_per_i    (out_per),
      .out_duty_i   (out_duty),
      .out_incr_i   (out_incr),
      .out_iter_i   (out_iter),
      .out_shift_i  (out_shift),
      .out_incr2_i  (out_incr2),
      .out_iter2_i  (out_iter2),
      .out_shift2_i (out_shift2),
      .out_delay_i  (out_delay)
   );

   always #2 clk = ~clk;

   function automatic logic [BUS_DATA_W-1:0] mem_word(input logic [BUS_ADDR_W-1:0] adr);
      return adr ^ MEM_KEY;
   endfunction

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
      chk_cnt++;
      if (exp !== act) begin
         err_cnt++;
         $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic report_problem(input string msg);
      err_cnt++;
      $display("%s: %s", cur_test, msg);
   endtask

   // Wishbone slave, one ack per strobe after a random wait
   always @(negedge clk) begin
      if (wb_cyc) begin
         cyc_seen = 1'b1;
      end
      if (wb_ack) begin
         // strobe gap right after each ack
         check("stb after ack", 0, wb_stb);
         if (xfer_cnt == read_len) begin
            check("cyc after last ack", 0, wb_cyc);
         end else begin
            check("cyc between words", 1, wb_cyc);
         end
         wb_ack   = 1'b0;
         ack_wait = $unsigned($random(seed)) % (max_delay + 1);
      end else if (wb_stb) begin
         if (ack_wait == 0) begin
            check("bus address", next_adr, wb_adr);
            wb_dat   = mem_word(wb_adr);
            wb_ack   = 1'b1;
            xfer_cnt = xfer_cnt + 1;
            next_adr = next_adr + BUS_BYTES;
         end else begin
            ack_wait = ack_wait - 1;
         end
      end
   end

   always @(negedge clk) begin
      if (data_valid) begin
         got_q.push_back(data);
      end
   end

   task automatic model_fill(input int half);
      int k;
      for (k = 0; k < read_len; k++) begin
         model_buf[half*HALF_SZ + k] = mem_word(ext_addr + k*BUS_BYTES);
      end
   endtask

   // start + m*shift2 + j*shift + k*incr, first duty slots of each period
   task automatic model_predict(input int half);
      int m;
      int j;
      int k;
      int a;
      int idx;
      logic [BUS_DATA_W-1:0] w;
      exp_q.delete();
      for (m = 0; m < out_iter2; m++) begin
         for (j = 0; j < out_iter; j++) begin
            for (k = 0; k < out_duty; k++) begin
               a = half*HALF_SZ + out_start % HALF_SZ + m*out_shift2 + j*out_shift
                   + k*out_incr;
               a = a % (2*HALF_SZ);
               idx = (a / HALF_SZ) * HALF_SZ + (a % HALF_SZ) / SYMS;
               w = model_buf[idx];
               exp_q.push_back(SYM_W'(w >> ((a % SYMS) * SYM_W)));
            end
         end
      end
   endtask

   task automatic set_linear(input int len, input int delay);
      read_len   = len;
      rd_per     = len;
      rd_duty    = len;
      rd_incr    = 1;
      rd_iter    = 1;
      rd_shift   = 0;
      out_start  = 0;
      out_per    = len * SYMS;
      out_duty   = len * SYMS;
      out_incr   = 1;
      out_iter   = 1;
      out_shift  = 0;
      out_incr2  = 0;
      out_iter2  = 1;
      out_shift2 = 0;
      out_delay  = delay;
   endtask

   task automatic launch();
      int wr_half;
      int rd_half;
      // write half is the inverse of the ping-pong state
      wr_half  = ping_pong ? !model_pp : 0;
      rd_half  = ping_pong ? model_pp : 0;
      model_pp = ping_pong ? !model_pp : 1'b0;
      if (read_en) begin
         model_fill(wr_half);
      end
      model_predict(rd_half);
      got_q.delete();
      xfer_cnt = 0;
      cyc_seen = 1'b0;
      next_adr = ext_addr;
      @(negedge clk);
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (!done && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!done) begin
         report_problem("done_o never came back high");
      end
      @(negedge clk);
   endtask

   task automatic compare_stream();
      int i;
      check("symbol count", exp_q.size(), got_q.size());
      for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
         check($sformatf("symbol %0d", i), exp_q[i], got_q[i]);
      end
   endtask

   task automatic end_test(input int err0);
      test_cnt++;
      $display("%s finished with %0d errors", cur_test, err_cnt - err0);
   endtask

   task automatic test_reset_run();
      int err0;
      err0 = err_cnt;
      cur_test = "reset_run";
      check("done after reset", 1, done);
      check("cyc after reset", 0, wb_cyc);
      check("valid after reset", 0, data_valid);
      set_linear(4, 4);
      launch();
      check("done one cycle after run", 0, done);
      wait_done();
      compare_stream();
      end_test(err0);
   endtask

   task automatic test_linear();
      int err0;
      int lat;
      err0 = err_cnt;
      cur_test = "linear";
      ext_addr = 32'h0000_1000;
      set_linear(8, 10);
      launch();
      check("cyc one cycle after run", 1, wb_cyc);
      lat = 1;
      while (!data_valid && lat < TIMEOUT) begin
         @(negedge clk);
         lat++;
      end
      if (!data_valid) begin
         report_problem("no output symbol appeared");
      end else begin
         // emission after delay + 1, then one more for the buffer read
         check("stream latency", out_delay + 2, lat);
      end
      wait_done();
      compare_stream();
      check("transfers", 8, xfer_cnt);
      end_test(err0);
   endtask

   task automatic test_two_level();
      int err0;
      err0 = err_cnt;
      cur_test = "two_level";
      ext_addr = 32'h0000_2000;
      set_linear(16, 60);
      out_start  = 3;
      out_per    = 5;
      out_duty   = 3;
      out_incr   = 2;
      out_iter   = 4;
      out_shift  = 7;
      out_iter2  = 3;
      out_shift2 = 13;
      launch();
      wait_done();
      compare_stream();
      end_test(err0);
   endtask

   task automatic test_ping_pong();
      int err0;
      err0 = err_cnt;
      cur_test = "ping_pong";
      ping_pong = 1'b1;
      ext_addr  = 32'h0000_3000;
      set_linear(8, 2);
      launch();
      wait_done();
      compare_stream();
      ext_addr = 32'h0000_4000;
      launch();
      wait_done();
      compare_stream();
      ping_pong = 1'b0;
      end_test(err0);
   endtask

   task automatic test_random_ack();
      int err0;
      err0 = err_cnt;
      cur_test = "random_ack";
      max_delay = 5;
      ext_addr  = 32'h0000_5000;
      // long start delay so the whole block lands before the stream
      set_linear(12, 120);
      launch();
      wait_done();
      compare_stream();
      check("transfers", 12, xfer_cnt);
      max_delay = 0;
      end_test(err0);
   endtask

   task automatic test_replay();
      int err0;
      err0 = err_cnt;
      cur_test = "replay";
      read_en = 1'b0;
      set_linear(12, 3);
      launch();
      wait_done();
      check("transfers", 0, xfer_cnt);
      check("bus cycle seen", 0, cyc_seen);
      compare_stream();
      read_en = 1'b1;
      end_test(err0);
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      run       = 1'b0;
      wb_ack    = 1'b0;
      wb_dat    = '0;
      ext_addr  = '0;
      read_en   = 1'b1;
      ping_pong = 1'b0;
      set_linear(1, 0);
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      repeat (2) @(negedge clk);
      test_reset_run();
      test_linear();
      test_two_level();
      test_ping_pong();
      test_random_ack();
      test_replay();
      $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== src.f ====
design/vread_bus_pkg.sv
design/vread_cfg_pkg.sv
design/vread_ctrl.sv
design/pattern_addr_gen.sv
design/buffer_writer.sv
design/dual_port_buffer.sv
design/symbol_select.sv
design/vread_top.sv
dv/tb_vread.sv
